/* src/llc_pkg.sv */
package llc_pkg;

    localparam int TAG_BITS = 8;
    localparam int SET_BITS = 4;
    localparam int LINE_BITS = 128;
    localparam int ID_BITS = 4;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_t;
    typedef logic [TAG_BITS+SET_BITS-1:0] line_addr_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [ID_BITS-1:0] req_id_t;

    // Tag in the upper bits, set index in the lower bits
    typedef struct packed {
        tag_t tag;
        set_t set;
    } addr_split_t;

    // Flat view for the memory channel, split view for lookup
    typedef union packed {
        line_addr_t  flat;
        addr_split_t split;
    } llc_addr_u;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FLUSH
    } llc_op_e;

endpackage

/* src/llc_ifs.sv */
`timescale 1ns/1ns

// Captured item handed from the input stage to the controller
interface llc_req_if;
    logic               pending;
    llc_pkg::llc_op_e   op;
    llc_pkg::llc_addr_u addr;
    llc_pkg::line_t     line;
    llc_pkg::req_id_t   id;
    logic               take;

    modport stage (output pending, op, addr, line, id, input take);
    modport ctrl (input pending, op, addr, line, id, output take);
endinterface

// Controller view of the way buffers
interface llc_buf_if #(
    parameter int WAYS = 4
);
    localparam int WAY_BITS = $clog2(WAYS);

    logic                hit;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] victim_way;
    logic                victim_valid;
    logic                victim_dirty;
    llc_pkg::tag_t       victim_tag;
    llc_pkg::line_t      victim_line;
    llc_pkg::line_t      way_line;
    logic [WAYS-1:0]     dirty_mask;

    llc_pkg::set_t       set_idx;
    logic                load;
    logic [WAY_BITS-1:0] wr_way;
    llc_pkg::line_t      wr_line;
    llc_pkg::tag_t       wr_tag;
    logic                wr_dirty;
    logic                wr_valid;
    logic                wr_strobe;
    logic                invalidate_all;
    logic                advance_ptr;
    logic                commit;

    modport buffer (
        output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag,
               victim_line, way_line, dirty_mask,
        input  set_idx, load, wr_way, wr_line, wr_tag, wr_dirty, wr_valid, wr_strobe,
               invalidate_all, advance_ptr, commit
    );
    modport ctrl (
        input  hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag,
               victim_line, way_line, dirty_mask,
        output set_idx, load, wr_way, wr_line, wr_tag, wr_dirty, wr_valid, wr_strobe,
               invalidate_all, advance_ptr, commit
    );
endinterface

// Whole-set access to local memory
interface llc_array_if #(
    parameter int WAYS = 4
);
    localparam int WAY_BITS = $clog2(WAYS);

    llc_pkg::set_t                  set_idx;
    logic                           rd_en;
    logic                           wr_en;
    llc_pkg::tag_t  [WAYS-1:0]      wr_tag;
    logic           [WAYS-1:0]      wr_valid;
    logic           [WAYS-1:0]      wr_dirty;
    llc_pkg::line_t [WAYS-1:0]      wr_line;
    logic           [WAY_BITS-1:0]  wr_ptr;
    llc_pkg::tag_t  [WAYS-1:0]      rd_tag;
    logic           [WAYS-1:0]      rd_valid;
    logic           [WAYS-1:0]      rd_dirty;
    llc_pkg::line_t [WAYS-1:0]      rd_line;
    logic           [WAY_BITS-1:0]  rd_ptr;

    modport client (
        output set_idx, rd_en, wr_en, wr_tag, wr_valid, wr_dirty, wr_line, wr_ptr,
        input  rd_tag, rd_valid, rd_dirty, rd_line, rd_ptr
    );
    modport array (
        input  set_idx, rd_en, wr_en, wr_tag, wr_valid, wr_dirty, wr_line, wr_ptr,
        output rd_tag, rd_valid, rd_dirty, rd_line, rd_ptr
    );
endinterface

/* src/llc_localmem.sv */
`timescale 1ns/1ns

module llc_localmem #(
    parameter int WAYS = 4
) (
    input logic        clk,
    input logic        rst,
    llc_array_if.array mem
);
    localparam int SETS = 1 << llc_pkg::SET_BITS;
    localparam int WAY_BITS = $clog2(WAYS);

    llc_pkg::tag_t  [WAYS-1:0] tag_mem [SETS];
    llc_pkg::line_t [WAYS-1:0] line_mem [SETS];
    logic [WAYS-1:0]           valid_mem [SETS];
    logic [WAYS-1:0]           dirty_mem [SETS];
    logic [WAY_BITS-1:0]       ptr_mem [SETS];

    // State bits and victim pointers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                ptr_mem[s] <= '0;
            end
        end else if (mem.wr_en) begin
            valid_mem[mem.set_idx] <= mem.wr_valid;
            dirty_mem[mem.set_idx] <= mem.wr_dirty;
            ptr_mem[mem.set_idx] <= mem.wr_ptr;
        end
    end

    // Tags, lines and the registered read port
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            tag_mem[mem.set_idx] <= mem.wr_tag;
            line_mem[mem.set_idx] <= mem.wr_line;
        end
        if (mem.rd_en) begin
            mem.rd_tag <= tag_mem[mem.set_idx];
            mem.rd_line <= line_mem[mem.set_idx];
            mem.rd_valid <= valid_mem[mem.set_idx];
            mem.rd_dirty <= dirty_mem[mem.set_idx];
            mem.rd_ptr <= ptr_mem[mem.set_idx];
        end
    end

    // Reads happen in READ and writes in UPDATE, never together
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst)
        !(mem.rd_en && mem.wr_en));

endmodule

/* src/llc_input_stage.sv */
`timescale 1ns/1ns

module llc_input_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  logic                req_write_i,
    input  llc_pkg::line_addr_t req_addr_i,
    input  llc_pkg::line_t      req_line_i,
    input  llc_pkg::req_id_t    req_id_i,
    input  logic                flush_valid_i,
    output logic                flush_ready_o,
    input  logic                decode_i,
    llc_req_if.stage            req
);
    logic req_fire;
    logic flush_fire;

    // Flush wins when both are offered
    assign flush_ready_o = decode_i && !req.pending;
    assign req_ready_o = flush_ready_o && !flush_valid_i;
    assign flush_fire = flush_valid_i && flush_ready_o;
    assign req_fire = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req.pending <= 1'b0;
            req.op <= llc_pkg::OP_READ;
        end else if (flush_fire) begin
            req.pending <= 1'b1;
            req.op <= llc_pkg::OP_FLUSH;
        end else if (req_fire) begin
            req.pending <= 1'b1;
            req.op <= req_write_i ? llc_pkg::OP_WRITE : llc_pkg::OP_READ;
        end else if (req.take) begin
            req.pending <= 1'b0;
        end
    end

    // Payload stays put until the next capture
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req.addr.flat <= req_addr_i;
            req.line <= req_line_i;
            req.id <= req_id_i;
        end
    end

    a_take_pending: assert property (@(posedge clk) disable iff (!rst)
        req.take |-> req.pending);

endmodule

/* src/llc_set_buffer.sv */
`timescale 1ns/1ns

module llc_set_buffer #(
    parameter int WAYS = 4
) (
    input logic          clk,
    input logic          rst,
    llc_buf_if.buffer    ctl,
    llc_array_if.client  arr
);
    localparam int WAY_BITS = $clog2(WAYS);

    llc_pkg::tag_t  [WAYS-1:0] tag_q, tag_v;
    llc_pkg::line_t [WAYS-1:0] line_q, line_v;
    logic [WAYS-1:0]           valid_q, valid_v;
    logic [WAYS-1:0]           dirty_q, dirty_v;
    logic [WAY_BITS-1:0]       ptr_q, ptr_v;
    logic                      load_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            load_q <= 1'b0;
        end else begin
            load_q <= ctl.load;
        end
    end

    // Read data shows straight through during LOOKUP
    assign tag_v = load_q ? arr.rd_tag : tag_q;
    assign line_v = load_q ? arr.rd_line : line_q;
    assign valid_v = load_q ? arr.rd_valid : valid_q;
    assign dirty_v = load_q ? arr.rd_dirty : dirty_q;
    assign ptr_v = load_q ? arr.rd_ptr : ptr_q;

    always_ff @(posedge clk) begin
        if (load_q) begin
            tag_q <= arr.rd_tag;
            line_q <= arr.rd_line;
            valid_q <= arr.rd_valid;
            dirty_q <= arr.rd_dirty;
            ptr_q <= arr.rd_ptr;
        end else begin
            if (ctl.wr_strobe) begin
                tag_q[ctl.wr_way] <= ctl.wr_tag;
                line_q[ctl.wr_way] <= ctl.wr_line;
                valid_q[ctl.wr_way] <= ctl.wr_valid;
                dirty_q[ctl.wr_way] <= ctl.wr_dirty;
            end
            if (ctl.invalidate_all) begin
                valid_q <= '0;
                dirty_q <= '0;
                ptr_q <= '0;
            end else if (ctl.advance_ptr && ptr_q == ctl.wr_way) begin
                // Round robin only moves when the fill used the pointer way
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // Tag compare against the request tag
    always_comb begin
        ctl.hit = 1'b0;
        ctl.hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_v[w] && tag_v[w] == ctl.wr_tag) begin
                ctl.hit = 1'b1;
                ctl.hit_way = WAY_BITS'(w);
            end
        end
    end

    // Lowest invalid way, else the pointer
    always_comb begin
        ctl.victim_way = ptr_v;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_v[w]) begin
                ctl.victim_way = WAY_BITS'(w);
            end
        end
    end

    // Victim fields follow the way the controller is working on
    assign ctl.victim_tag = tag_v[ctl.wr_way];
    assign ctl.victim_line = line_v[ctl.wr_way];
    assign ctl.victim_valid = valid_v[ctl.wr_way];
    assign ctl.victim_dirty = dirty_v[ctl.wr_way];
    assign ctl.way_line = line_v[ctl.hit_way];
    assign ctl.dirty_mask = valid_v & dirty_v;

    assign arr.set_idx = ctl.set_idx;
    assign arr.rd_en = ctl.load;
    assign arr.wr_en = ctl.commit;
    assign arr.wr_tag = tag_q;
    assign arr.wr_line = line_q;
    assign arr.wr_valid = valid_q;
    assign arr.wr_dirty = dirty_q;
    assign arr.wr_ptr = ptr_q;

endmodule

/* src/llc_ctrl.sv */
`timescale 1ns/1ns

module llc_ctrl #(
    parameter int WAYS = 4
) (
    input  logic                clk,
    input  logic                rst,
    output logic                decode_o,
    llc_req_if.ctrl             req,
    llc_buf_if.ctrl             ctl,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output llc_pkg::req_id_t    rsp_id_o,
    output llc_pkg::line_t      rsp_line_o,
    output logic                rsp_hit_o,
    output logic                mem_req_valid_o,
    input  logic                mem_req_ready_i,
    output logic                mem_req_write_o,
    output llc_pkg::line_addr_t mem_req_addr_o,
    output llc_pkg::line_t      mem_req_line_o,
    input  logic                mem_rsp_valid_i,
    output logic                mem_rsp_ready_o,
    input  llc_pkg::line_t      mem_rsp_line_i,
    output logic                flush_done_valid_o,
    input  logic                flush_done_ready_i
);
    localparam int WAY_BITS = $clog2(WAYS);

    localparam logic [2:0] DECODE = 3'b000;
    localparam logic [2:0] READ = 3'b001;
    localparam logic [2:0] LOOKUP = 3'b011;
    localparam logic [2:0] PROCESS = 3'b010;
    localparam logic [2:0] UPDATE = 3'b110;

    logic [2:0]          state, next_state;
    logic                hit_q, wb_q, rd_q, fill_q, flushing_q;
    logic [WAY_BITS-1:0] way_q, flush_way;
    logic [WAYS-1:0]     done_mask_q, todo_mask;
    llc_pkg::set_t       flush_set_q;
    llc_pkg::llc_addr_u  wb_addr;
    logic                in_process, is_read, is_write, last_set;
    logic                wb_phase, rd_phase, fill_phase, rsp_phase, flush_wb;
    logic                rsp_fire, mem_req_fire, mem_rsp_fire, done_fire, process_done;

    assign in_process = state == PROCESS;
    assign is_read = req.op == llc_pkg::OP_READ;
    assign is_write = req.op == llc_pkg::OP_WRITE;
    assign last_set = flush_set_q == '1;

    // Miss sequence: write-back, read request, fill, response
    assign wb_phase = !flushing_q && !hit_q && ctl.victim_valid && ctl.victim_dirty && !wb_q;
    assign rd_phase = !flushing_q && !hit_q && is_read && !wb_phase && !rd_q;
    assign fill_phase = !flushing_q && !hit_q && is_read && rd_q && !fill_q;
    assign rsp_phase = !flushing_q && !wb_phase && !rd_phase && !fill_phase;

    // Flush writes back dirty ways lowest first
    assign todo_mask = ctl.dirty_mask & ~done_mask_q;
    assign flush_wb = flushing_q && |todo_mask;

    always_comb begin
        flush_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (todo_mask[w]) begin
                flush_way = WAY_BITS'(w);
            end
        end
    end

    always_comb begin
        wb_addr.split.tag = ctl.victim_tag;
        wb_addr.split.set = ctl.set_idx;
    end

    assign rsp_valid_o = in_process && rsp_phase;
    assign rsp_id_o = req.id;
    assign rsp_line_o = is_write ? req.line : ctl.way_line;
    assign rsp_hit_o = hit_q;
    assign mem_req_valid_o = in_process && (wb_phase || rd_phase || flush_wb);
    assign mem_req_write_o = wb_phase || flush_wb;
    assign mem_req_addr_o = (wb_phase || flushing_q) ? wb_addr.flat : req.addr.flat;
    assign mem_req_line_o = ctl.victim_line;
    assign mem_rsp_ready_o = in_process && fill_phase;
    assign flush_done_valid_o = in_process && flushing_q && !flush_wb && last_set;

    assign rsp_fire = rsp_valid_o && rsp_ready_i;
    assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
    assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;
    assign done_fire = flush_done_valid_o && flush_done_ready_i;
    assign process_done = in_process &&
        (flushing_q ? (!flush_wb && (!last_set || done_fire)) : rsp_fire);

    assign decode_o = state == DECODE && !flushing_q;
    assign req.take = decode_o && req.pending;

    assign ctl.set_idx = flushing_q ? flush_set_q : req.addr.split.set;
    assign ctl.load = state == READ;
    assign ctl.wr_way = flushing_q ? flush_way : way_q;
    assign ctl.wr_tag = req.addr.split.tag;
    assign ctl.wr_line = is_write ? req.line : mem_rsp_line_i;
    assign ctl.wr_dirty = is_write;
    assign ctl.wr_valid = 1'b1;
    assign ctl.wr_strobe = mem_rsp_fire || (rsp_fire && is_write);
    assign ctl.invalidate_all = process_done && flushing_q;
    assign ctl.advance_ptr = process_done && !flushing_q && !hit_q;
    assign ctl.commit = state == UPDATE;

    always_comb begin
        next_state = state;
        case (state)
            DECODE: begin
                if (flushing_q || req.pending) begin
                    next_state = READ;
                end
            end
            READ: next_state = LOOKUP;
            LOOKUP: next_state = PROCESS;
            PROCESS: begin
                if (process_done) begin
                    next_state = UPDATE;
                end
            end
            UPDATE: next_state = DECODE;
            default: next_state = DECODE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DECODE;
            hit_q <= 1'b0;
            way_q <= '0;
            wb_q <= 1'b0;
            rd_q <= 1'b0;
            fill_q <= 1'b0;
            done_mask_q <= '0;
            flushing_q <= 1'b0;
            flush_set_q <= '0;
        end else begin
            state <= next_state;
            if (state == LOOKUP) begin
                hit_q <= ctl.hit;
                way_q <= ctl.hit ? ctl.hit_way : ctl.victim_way;
                wb_q <= 1'b0;
                rd_q <= 1'b0;
                fill_q <= 1'b0;
                done_mask_q <= '0;
            end
            if (mem_req_fire) begin
                if (flushing_q) begin
                    done_mask_q[flush_way] <= 1'b1;
                end else if (wb_phase) begin
                    wb_q <= 1'b1;
                end else begin
                    rd_q <= 1'b1;
                end
            end
            if (mem_rsp_fire) begin
                fill_q <= 1'b1;
            end
            if (req.take && req.op == llc_pkg::OP_FLUSH) begin
                flushing_q <= 1'b1;
            end
            // Walk ends after the last set is committed
            if (state == UPDATE && flushing_q) begin
                flush_set_q <= flush_set_q + 1'b1;
                if (last_set) begin
                    flushing_q <= 1'b0;
                end
            end
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o && !rsp_ready_i |=>
        rsp_valid_o && $stable({rsp_id_o, rsp_line_o, rsp_hit_o}));

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o && !mem_req_ready_i |=>
        mem_req_valid_o && $stable({mem_req_write_o, mem_req_addr_o, mem_req_line_o}));

endmodule

/* src/llc_top.sv */
`timescale 1ns/1ns

module llc_top #(
    parameter int WAYS = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  logic                req_write_i,
    input  llc_pkg::line_addr_t req_addr_i,
    input  llc_pkg::line_t      req_line_i,
    input  llc_pkg::req_id_t    req_id_i,
    input  logic                flush_valid_i,
    output logic                flush_ready_o,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output llc_pkg::req_id_t    rsp_id_o,
    output llc_pkg::line_t      rsp_line_o,
    output logic                rsp_hit_o,
    output logic                mem_req_valid_o,
    input  logic                mem_req_ready_i,
    output logic                mem_req_write_o,
    output llc_pkg::line_addr_t mem_req_addr_o,
    output llc_pkg::line_t      mem_req_line_o,
    input  logic                mem_rsp_valid_i,
    output logic                mem_rsp_ready_o,
    input  llc_pkg::line_t      mem_rsp_line_i,
    output logic                flush_done_valid_o,
    input  logic                flush_done_ready_i
);
    logic decode;

    llc_req_if req_if ();
    llc_buf_if #(.WAYS(WAYS)) buf_if ();
    llc_array_if #(.WAYS(WAYS)) arr_if ();

    llc_input_stage input_stage_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_write_i   (req_write_i),
        .req_addr_i    (req_addr_i),
        .req_line_i    (req_line_i),
        .req_id_i      (req_id_i),
        .flush_valid_i (flush_valid_i),
        .flush_ready_o (flush_ready_o),
        .decode_i      (decode),
        .req           (req_if.stage)
    );

    llc_ctrl #(.WAYS(WAYS)) ctrl_i (
        .clk                (clk),
        .rst                (rst),
        .decode_o           (decode),
        .req                (req_if.ctrl),
        .ctl                (buf_if.ctrl),
        .rsp_valid_o        (rsp_valid_o),
        .rsp_ready_i        (rsp_ready_i),
        .rsp_id_o           (rsp_id_o),
        .rsp_line_o         (rsp_line_o),
        .rsp_hit_o          (rsp_hit_o),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_req_write_o    (mem_req_write_o),
        .mem_req_addr_o     (mem_req_addr_o),
        .mem_req_line_o     (mem_req_line_o),
        .mem_rsp_valid_i    (mem_rsp_valid_i),
        .mem_rsp_ready_o    (mem_rsp_ready_o),
        .mem_rsp_line_i     (mem_rsp_line_i),
        .flush_done_valid_o (flush_done_valid_o),
        .flush_done_ready_i (flush_done_ready_i)
    );

    llc_set_buffer #(.WAYS(WAYS)) set_buffer_i (
        .clk (clk),
        .rst (rst),
        .ctl (buf_if.buffer),
        .arr (arr_if.client)
    );

    llc_localmem #(.WAYS(WAYS)) localmem_i (
        .clk (clk),
        .rst (rst),
        .mem (arr_if.array)
    );

endmodule

/* bench/llc_tb_clock.sv */
`timescale 1ns/1ns

module llc_tb_clock #(
    parameter int PERIOD = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end
endmodule

/* bench/llc_tb.sv */
`timescale 1ns/1ns

module llc_tb;
    localparam int WAYS = 4;
    localparam int SETS = 1 << llc_pkg::SET_BITS;
    localparam int N_RAND = 400;
    localparam int N_TAIL = 32;
    localparam int WATCHDOG_CYCLES = 200 * (N_RAND + N_TAIL + 1);

    logic clk;
    logic rst;
    logic req_valid_i, req_ready_o, req_write_i;
    llc_pkg::line_addr_t req_addr_i;
    llc_pkg::line_t req_line_i;
    llc_pkg::req_id_t req_id_i;
    logic flush_valid_i, flush_ready_o;
    logic rsp_valid_o, rsp_ready_i, rsp_hit_o;
    llc_pkg::req_id_t rsp_id_o;
    llc_pkg::line_t rsp_line_o;
    logic mem_req_valid_o, mem_req_ready_i, mem_req_write_o;
    llc_pkg::line_addr_t mem_req_addr_o;
    llc_pkg::line_t mem_req_line_o;
    logic mem_rsp_valid_i, mem_rsp_ready_o;
    llc_pkg::line_t mem_rsp_line_i;
    logic flush_done_valid_o, flush_done_ready_i;

    logic [15:0] lfsr;
    int errors;
    int txn_count;

    // Cache model and backing memory
    llc_pkg::tag_t m_tag [SETS][WAYS];
    llc_pkg::line_t m_line [SETS][WAYS];
    logic m_valid [SETS][WAYS];
    logic m_dirty [SETS][WAYS];
    logic [$clog2(WAYS)-1:0] m_ptr [SETS];
    llc_pkg::line_t mem_data [llc_pkg::line_addr_t];

    // Expected traffic
    logic mreq_write_q [$];
    llc_pkg::line_addr_t mreq_addr_q [$];
    llc_pkg::line_t mreq_line_q [$];
    llc_pkg::line_t fill_q [$];
    logic rsp_expected, done_expected, exp_hit;
    llc_pkg::req_id_t exp_id;
    llc_pkg::line_t exp_line;
    logic in_flight;

    // Staged inputs for the next falling edge
    logic req_launch, flush_launch, next_write;
    llc_pkg::line_addr_t next_addr;
    llc_pkg::line_t next_line;
    llc_pkg::req_id_t next_id;
    logic req_fired, flush_fired, mem_rsp_fired;

    llc_tb_clock clock_i (.clk_o(clk), .rst_o(rst));

    llc_top #(.WAYS(WAYS)) dut_i (.*);

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic llc_pkg::line_t rand_line();
        llc_pkg::line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = rand_bits(32);
        end
        return l;
    endfunction

    // Mostly a few tags over a few sets so that lines collide
    function automatic llc_pkg::line_addr_t rand_addr();
        logic [1:0] r;
        llc_pkg::tag_t t;
        if (rand_bits(3) == 0) begin
            return llc_pkg::line_addr_t'(rand_bits(12));
        end
        r = 2'(rand_bits(2));
        t = 8'h40 + llc_pkg::tag_t'(rand_bits(3));
        return {t, r, 2'b10};
    endfunction

    function automatic llc_pkg::line_t mem_read(llc_pkg::line_addr_t a);
        if (mem_data.exists(a)) begin
            return mem_data[a];
        end
        return {8{4'h0, a}};
    endfunction

    task automatic check(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic flag_error(string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic expect_mem(logic write, llc_pkg::line_addr_t a, llc_pkg::line_t l);
        mreq_write_q.push_back(write);
        mreq_addr_q.push_back(a);
        mreq_line_q.push_back(l);
        if (write) begin
            mem_data[a] = l;
        end
    endtask

    task automatic predict_request(logic write, llc_pkg::line_addr_t a, llc_pkg::line_t l,
                                   llc_pkg::req_id_t id);
        llc_pkg::set_t s;
        llc_pkg::tag_t t;
        int way;
        logic hit;
        s = a[3:0];
        t = a[11:4];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = m_ptr[s];
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!m_valid[s][w]) begin
                    way = w;
                end
            end
            if (m_valid[s][way] && m_dirty[s][way]) begin
                expect_mem(1'b1, {m_tag[s][way], s}, m_line[s][way]);
            end
            if (!write) begin
                expect_mem(1'b0, a, '0);
            end
            if (way == m_ptr[s]) begin
                m_ptr[s] = m_ptr[s] + 1'b1;
            end
            m_tag[s][way] = t;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
            m_line[s][way] = mem_read(a);
        end
        if (write) begin
            m_line[s][way] = l;
            m_dirty[s][way] = 1'b1;
        end
        exp_id = id;
        exp_hit = hit;
        exp_line = m_line[s][way];
    endtask

    task automatic predict_flush();
        llc_pkg::set_t s;
        for (int i = 0; i < SETS; i++) begin
            s = llc_pkg::set_t'(i);
            for (int w = 0; w < WAYS; w++) begin
                if (m_valid[i][w] && m_dirty[i][w]) begin
                    expect_mem(1'b1, {m_tag[i][w], s}, m_line[i][w]);
                end
                m_valid[i][w] = 1'b0;
                m_dirty[i][w] = 1'b0;
            end
            m_ptr[i] = '0;
        end
    endtask

    task automatic take_mem_req();
        logic w;
        if (mreq_write_q.size() == 0) begin
            flag_error("memory request that the model does not expect");
        end else begin
            w = mreq_write_q.pop_front();
            check("mem_req_write_o", mem_req_write_o, w);
            check("mem_req_addr_o", mem_req_addr_o, mreq_addr_q.pop_front());
            if (w) begin
                check("mem_req_line_o", mem_req_line_o, mreq_line_q.pop_front());
            end else begin
                void'(mreq_line_q.pop_front());
            end
        end
        if (!mem_req_write_o) begin
            fill_q.push_back(mem_read(mem_req_addr_o));
        end
    endtask

    // Drive on the falling edge and sample what fires at the next rising edge
    task automatic cycle();
        @(negedge clk);
        if (req_fired) req_valid_i = 1'b0;
        if (flush_fired) flush_valid_i = 1'b0;
        if (mem_rsp_fired) mem_rsp_valid_i = 1'b0;
        req_fired = 1'b0;
        flush_fired = 1'b0;
        mem_rsp_fired = 1'b0;
        if (req_launch) begin
            req_valid_i = 1'b1;
            req_write_i = next_write;
            req_addr_i = next_addr;
            req_line_i = next_line;
            req_id_i = next_id;
            req_launch = 1'b0;
        end
        if (flush_launch) begin
            flush_valid_i = 1'b1;
            flush_launch = 1'b0;
        end
        rsp_ready_i = rand_bits(2) != 0;
        mem_req_ready_i = rand_bits(2) != 0;
        flush_done_ready_i = rand_bits(2) != 0;
        if (!mem_rsp_valid_i && fill_q.size() > 0 && rand_bits(1) == 1) begin
            mem_rsp_valid_i = 1'b1;
            mem_rsp_line_i = fill_q[0];
        end
        #1;
        // Nothing new is accepted while an item is in flight
        if (in_flight) begin
            check("req_ready_o", req_ready_o, 1'b0);
            check("flush_ready_o", flush_ready_o, 1'b0);
        end
        if (fill_q.size() == 0) begin
            check("mem_rsp_ready_o", mem_rsp_ready_o, 1'b0);
        end
        req_fired = req_valid_i && req_ready_o;
        flush_fired = flush_valid_i && flush_ready_o;
        if (req_fired || flush_fired) in_flight = 1'b1;
        if (rsp_valid_o && rsp_ready_i) begin
            if (!rsp_expected) begin
                flag_error("response without an outstanding request");
            end else begin
                check("rsp_id_o", rsp_id_o, exp_id);
                check("rsp_line_o", rsp_line_o, exp_line);
                check("rsp_hit_o", rsp_hit_o, exp_hit);
                rsp_expected = 1'b0;
            end
            in_flight = 1'b0;
        end
        if (mem_req_valid_o && mem_req_ready_i) take_mem_req();
        if (mem_rsp_valid_i && mem_rsp_ready_o) begin
            void'(fill_q.pop_front());
            mem_rsp_fired = 1'b1;
        end
        if (flush_done_valid_o && flush_done_ready_i) begin
            if (!done_expected) flag_error("flush done without a flush in progress");
            done_expected = 1'b0;
            in_flight = 1'b0;
        end
    endtask

    task automatic serve_request(logic write, llc_pkg::line_addr_t a, llc_pkg::line_t l,
                                 llc_pkg::req_id_t id);
        predict_request(write, a, l, id);
        next_write = write;
        next_addr = a;
        next_line = l;
        next_id = id;
        req_launch = 1'b1;
        rsp_expected = 1'b1;
        while (rsp_expected) cycle();
        if (mreq_write_q.size() != 0 || fill_q.size() != 0) begin
            flag_error("memory traffic still outstanding after the response");
        end
        txn_count++;
    endtask

    task automatic serve_flush();
        predict_flush();
        flush_launch = 1'b1;
        done_expected = 1'b1;
        while (done_expected) cycle();
        if (mreq_write_q.size() != 0) flag_error("flush finished with write-backs missing");
        txn_count++;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles, errors so far %0d",
                 WATCHDOG_CYCLES, errors);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i = '0;
        req_line_i = '0;
        req_id_i = '0;
        flush_valid_i = 1'b0;
        rsp_ready_i = 1'b0;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_line_i = '0;
        flush_done_ready_i = 1'b0;
        lfsr = 16'd19;
        errors = 0;
        txn_count = 0;
        {req_launch, flush_launch, req_fired, flush_fired, mem_rsp_fired} = '0;
        {rsp_expected, done_expected, in_flight} = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
            m_ptr[s] = '0;
        end

        @(posedge rst);
        #1;
        check("rsp_valid_o", rsp_valid_o, 1'b0);
        check("mem_req_valid_o", mem_req_valid_o, 1'b0);
        check("flush_done_valid_o", flush_done_valid_o, 1'b0);

        for (int i = 0; i < N_RAND; i++) begin
            if (rand_bits(5) == 0) begin
                serve_flush();
            end else begin
                serve_request(1'(rand_bits(1)), rand_addr(), rand_line(),
                              llc_pkg::req_id_t'(rand_bits(4)));
            end
            repeat (rand_bits(2)) cycle();
        end
        // Reads after a flush start from an empty cache
        serve_flush();
        for (int i = 0; i < N_TAIL; i++) begin
            serve_request(1'b0, rand_addr(), '0, llc_pkg::req_id_t'(rand_bits(4)));
        end

        $display("errors: %0d in %0d transactions", errors, txn_count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end
endmodule

/* llc.f */
src/llc_pkg.sv
src/llc_ifs.sv
src/llc_localmem.sv
src/llc_input_stage.sv
src/llc_set_buffer.sv
src/llc_ctrl.sv
src/llc_top.sv
bench/llc_tb_clock.sv
bench/llc_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = llc_tb
FILELIST = llc.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# The log decides the verdict, so a missing pass line fails the target
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
